// ==== Makefile ====
# Verilator lint, simulation and clean

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module core_tb
	verilator --lint-only -f filelist.f --top-module core_top

sim:
	verilator --binary --timing --assert -f filelist.f --top-module core_tb -Mdir obj_dir
	./obj_dir/Vcore_tb | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
+incdir+include
source/core_pkg.sv
source/pipe_reg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/hazard_detection.sv
source/reg_file.sv
source/exec_unit.sv
source/core_top.sv
tests/core_tb_asserts.sv
tests/core_tb.sv

// ==== include/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

//******************************
// core sizing
//******************************

// data and instruction width
`define CORE_WORD_W 16

// architectural registers, r0 included
`define CORE_NREGS 16

//******************************
// halt timing
//******************************

// cycles from HLT in decode to halted high
`define CORE_HLT_DRAIN 3

`endif

// ==== source/core_pkg.sv ====
package core_pkg;

`include "core_defines.svh"

	// basic datapath types
	typedef logic [`CORE_WORD_W-1:0] word_t;
	typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

	//******************************
	// opcodes, instr[15:12]
	//******************************
	typedef enum logic [3:0] {
		OP_ADD = 4'b0000,
		OP_SUB = 4'b0001,
		OP_XOR = 4'b0010,
		OP_LW  = 4'b1000, // rd <- mem[rs + sext(imm4)]
		OP_SW  = 4'b1001, // mem[rs + sext(imm4)] <- rd
		OP_LHB = 4'b1010, // upper byte of rd
		OP_LLB = 4'b1011, // lower byte of rd
		OP_HLT = 4'b1111
	} opcode_t; // anything else decodes as a nop

	//******************************
	// stage payloads
	//******************************

	// fetch -> decode
	typedef struct packed {
		word_t instr;
		word_t pc;
	} if_id_t;

	// decode -> execute
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t rd;         // destination
		reg_idx_t rs_idx;     // index behind op_a, for forwarding
		reg_idx_t rt_idx;     // index behind op_b
		word_t op_a;
		word_t op_b;
		logic [7:0] imm8;     // LHB / LLB byte
		word_t offset;        // sign-extended imm4
		logic we;             // writes rd at write-back
		logic mem_to_reg;     // LW
	} id_ex_t;

endpackage

// ==== source/core_top.sv ====
`timescale 1ns/100ps

module core_top (
	input logic clk,
	input logic rst_n,
	input core_pkg::word_t instr_data,
	input core_pkg::word_t dmem_rdata,
	output core_pkg::word_t instr_addr,
	output core_pkg::word_t dmem_addr,
	output core_pkg::word_t dmem_wdata,
	output logic dmem_we,
	output logic wb_en,
	output core_pkg::reg_idx_t wb_reg,
	output core_pkg::word_t wb_data,
	output logic stall,
	output logic halted
);

	import core_pkg::*;

	logic fetch_valid;
	if_id_t if_id_q;
	logic if_id_valid;
	id_ex_t id_ex_d, id_ex_q;
	logic id_ex_valid;
	reg_idx_t raddr_a, raddr_b;
	word_t rdata_a, rdata_b;
	reg_idx_t src_rs, src_rt;
	logic uses_rs, uses_rt;
	logic is_hlt;

	//******************************
	// fetch
	//******************************
	fetch_unit u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.instr_addr(instr_addr),
		.fetch_valid(fetch_valid)
	);

	// held on stall, empty until fetch is armed
	pipe_reg #(.payload_t(if_id_t)) u_if_id (
		.clk(clk),
		.rst_n(rst_n),
		.hold(stall),
		.bubble(!fetch_valid),
		.d(if_id_t'({instr_data, instr_addr})),
		.q(if_id_q),
		.valid(if_id_valid)
	);

	//******************************
	// decode
	//******************************
	decode_unit u_decode (
		.if_id(if_id_q),
		.if_id_valid(if_id_valid),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.src_rs(src_rs),
		.src_rt(src_rt),
		.uses_rs(uses_rs),
		.uses_rt(uses_rt),
		.is_hlt(is_hlt),
		.id_ex(id_ex_d)
	);

	hazard_detection u_hazard (
		.clk(clk),
		.rst_n(rst_n),
		.src_rs(src_rs),
		.src_rt(src_rt),
		.uses_rs(uses_rs),
		.uses_rt(uses_rt),
		.is_hlt(is_hlt),
		.id_ex_rd(id_ex_q.rd),
		.id_ex_mem_to_reg(id_ex_q.mem_to_reg),
		.id_ex_valid(id_ex_valid),
		.stall(stall),
		.halted(halted)
	);

	reg_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.we(wb_en),
		.waddr(wb_reg),
		.wdata(wb_data),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b)
	);

	// stall pushes a bubble into execute
	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk(clk),
		.rst_n(rst_n),
		.hold(1'b0),
		.bubble(stall),
		.d(id_ex_d),
		.q(id_ex_q),
		.valid(id_ex_valid)
	);

	//******************************
	// execute, memory, write-back
	//******************************
	exec_unit u_exec (
		.clk(clk),
		.rst_n(rst_n),
		.id_ex(id_ex_q),
		.id_ex_valid(id_ex_valid),
		.dmem_rdata(dmem_rdata),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

endmodule

// ==== source/decode_unit.sv ====
`timescale 1ns/100ps

`include "core_defines.svh"

module decode_unit (
	input core_pkg::if_id_t if_id,
	input logic if_id_valid,
	input core_pkg::word_t rdata_a,
	input core_pkg::word_t rdata_b,
	output core_pkg::reg_idx_t raddr_a,
	output core_pkg::reg_idx_t raddr_b,
	output core_pkg::reg_idx_t src_rs,
	output core_pkg::reg_idx_t src_rt,
	output logic uses_rs,
	output logic uses_rt,
	output logic is_hlt,
	output core_pkg::id_ex_t id_ex
);

	import core_pkg::*;

	opcode_t op;
	reg_idx_t f_rd, f_rs, f_rt;
	logic is_alu, is_lw, is_sw, is_byte;

	//******************************
	// field extraction
	//******************************
	assign op = opcode_t'(if_id.instr[15:12]);
	assign f_rd = if_id.instr[11:8];
	assign f_rs = if_id.instr[7:4];
	assign f_rt = if_id.instr[3:0];

	assign is_alu = (op == OP_ADD) || (op == OP_SUB) || (op == OP_XOR);
	assign is_lw = (op == OP_LW);
	assign is_sw = (op == OP_SW);
	assign is_byte = (op == OP_LHB) || (op == OP_LLB);

	// SW reads rd as store data, LHB/LLB read the old rd
	assign src_rs = (is_sw || is_byte) ? f_rd : f_rs;
	// memory ops take the base from [7:4]
	assign src_rt = (is_sw || is_lw) ? f_rs : f_rt;

	assign raddr_a = src_rs;
	assign raddr_b = src_rt;

	// which sources matter for the load-use check
	assign uses_rs = if_id_valid && (is_alu || is_lw || is_sw || is_byte);
	assign uses_rt = if_id_valid && (is_alu || is_sw);
	assign is_hlt = if_id_valid && (op == OP_HLT);

	//******************************
	// ID/EX payload
	//******************************
	always_comb begin
		id_ex = '0; // invalid slot decodes to a harmless ADD, no write
		if (if_id_valid) begin
			id_ex.opcode = op;
			id_ex.rd = f_rd;
			id_ex.rs_idx = src_rs;
			id_ex.rt_idx = src_rt;
			id_ex.op_a = rdata_a; // write-through already applied
			id_ex.op_b = rdata_b;
			id_ex.imm8 = if_id.instr[7:0];
			id_ex.offset = {{(`CORE_WORD_W-4){f_rt[3]}}, f_rt};
			id_ex.we = is_alu || is_lw || is_byte; // SW, HLT, nops write nothing
			id_ex.mem_to_reg = is_lw;
		end
	end

endmodule

// ==== source/exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit (
	input logic clk,
	input logic rst_n,
	input core_pkg::id_ex_t id_ex,
	input logic id_ex_valid,
	input core_pkg::word_t dmem_rdata,
	output core_pkg::word_t dmem_addr,
	output core_pkg::word_t dmem_wdata,
	output logic dmem_we,
	output logic wb_en,
	output core_pkg::reg_idx_t wb_reg,
	output core_pkg::word_t wb_data
);

	import core_pkg::*;

	word_t op_a, op_b;
	word_t ex_result;
	logic ex_store;

	// EX/MEM state
	word_t exm_result;   // ALU value or memory address
	word_t exm_sdata;    // store data
	reg_idx_t exm_rd;
	logic exm_we;
	logic exm_store;
	logic exm_mem_to_reg;

	//******************************
	// forwarding from MEM
	//******************************
	assign op_a = (wb_en && (wb_reg == id_ex.rs_idx)) ? wb_data : id_ex.op_a;
	assign op_b = (wb_en && (wb_reg == id_ex.rt_idx)) ? wb_data : id_ex.op_b;

	//******************************
	// ALU / address / byte insert
	//******************************
	always_comb begin
		case (id_ex.opcode)
			OP_ADD: ex_result = op_a + op_b;
			OP_SUB: ex_result = op_a - op_b;
			OP_XOR: ex_result = op_a ^ op_b;
			OP_LW: ex_result = op_a + id_ex.offset; // base in op_a
			OP_SW: ex_result = op_b + id_ex.offset; // base in op_b, data in op_a
			OP_LHB: ex_result = {id_ex.imm8, op_a[7:0]};
			OP_LLB: ex_result = {op_a[15:8], id_ex.imm8};
			default: ex_result = '0; // nop, HLT
		endcase
	end

	assign ex_store = id_ex_valid && (id_ex.opcode == OP_SW);

	// EX/MEM controls
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exm_we <= 1'b0;
			exm_store <= 1'b0;
			exm_mem_to_reg <= 1'b0;
		end else begin
			exm_we <= id_ex_valid && id_ex.we;
			exm_store <= ex_store;
			exm_mem_to_reg <= id_ex_valid && id_ex.mem_to_reg;
		end
	end

	always_ff @(posedge clk) begin
		exm_result <= ex_result;
		exm_sdata <= op_a;
		exm_rd <= id_ex.rd;
	end

	//******************************
	// memory / write-back
	//******************************
	assign dmem_addr = exm_result;
	assign dmem_wdata = exm_sdata;
	assign dmem_we = exm_store;

	assign wb_en = exm_we;
	assign wb_reg = exm_rd;
	assign wb_data = exm_mem_to_reg ? dmem_rdata : exm_result; // load data comb from dmem

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit (
	input logic clk,
	input logic rst_n,
	input logic stall,
	output core_pkg::word_t instr_addr,
	output logic fetch_valid
);

	import core_pkg::*;

	word_t pc;

	// first cycle out of reset only arms fetch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= 1'b1;
		end
	end

	//******************************
	// program counter
	//******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (fetch_valid && !stall) begin
			pc <= pc + word_t'(1); // word addressed, step by one
		end
	end

	// imem answers in the same cycle
	assign instr_addr = pc;

endmodule

// ==== source/hazard_detection.sv ====
`timescale 1ns/100ps

`include "core_defines.svh"

module hazard_detection (
	input logic clk,
	input logic rst_n,
	input core_pkg::reg_idx_t src_rs,
	input core_pkg::reg_idx_t src_rt,
	input logic uses_rs,
	input logic uses_rt,
	input logic is_hlt,          // HLT sitting in decode
	input core_pkg::reg_idx_t id_ex_rd,
	input logic id_ex_mem_to_reg,
	input logic id_ex_valid,
	output logic stall,
	output logic halted
);

	logic load_in_ex;
	logic load_use;
	logic [`CORE_HLT_DRAIN-1:0] hlt_sr;
	logic hlt_rise;

	//******************************
	// load-use
	//******************************

	// load in execute whose rd is read in decode
	assign load_in_ex = id_ex_valid && id_ex_mem_to_reg;
	assign load_use = load_in_ex &&
		((uses_rs && (src_rs == id_ex_rd)) || (uses_rt && (src_rt == id_ex_rd)));
	// bubble clears ID/EX valid, so this drops after one cycle

	//******************************
	// halt
	//******************************

	// drain delay, older instructions leave EX and MEM meanwhile
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hlt_sr <= '0;
		end else begin
			hlt_sr <= {hlt_sr[`CORE_HLT_DRAIN-2:0], is_hlt};
		end
	end

	// edge seen one stage before the end so halted lands on the drain count
	assign hlt_rise = hlt_sr[`CORE_HLT_DRAIN-2] & ~hlt_sr[`CORE_HLT_DRAIN-1];

	// sticky until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halted <= 1'b0;
		end else if (hlt_rise) begin
			halted <= 1'b1;
		end
	end

	// HLT keeps fetch frozen the whole time it is in decode
	assign stall = load_use | is_hlt | halted;

endmodule

// ==== source/pipe_reg.sv ====
`timescale 1ns/100ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst_n,
	input logic hold,   // keep current contents
	input logic bubble, // load an empty, invalid slot
	input payload_t d,
	output payload_t q,
	output logic valid
);

	// slot valid flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else if (bubble) begin
			valid <= 1'b0;
		end else if (!hold) begin
			valid <= 1'b1;
		end
	end

	// payload itself
	always_ff @(posedge clk) begin
		if (bubble) begin
			q <= '0; // empty slot
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/100ps

`include "core_defines.svh"

module reg_file (
	input logic clk,
	input logic rst_n,
	input core_pkg::reg_idx_t raddr_a,
	input core_pkg::reg_idx_t raddr_b,
	input logic we,
	input core_pkg::reg_idx_t waddr,
	input core_pkg::word_t wdata,
	output core_pkg::word_t rdata_a,
	output core_pkg::word_t rdata_b
);

	import core_pkg::*;

	word_t regs [`CORE_NREGS]; // r0 is a normal register

	// write at end of the memory/write-back cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	//******************************
	// read ports with write-through
	//******************************
	assign rdata_a = (we && (waddr == raddr_a)) ? wdata : regs[raddr_a];
	assign rdata_b = (we && (waddr == raddr_b)) ? wdata : regs[raddr_b];

endmodule

// ==== tests/core_tb.sv ====
`timescale 1ns/100ps

`include "core_defines.svh"

module core_tb;

	import core_pkg::*;

	localparam int IMEM_N = 64;
	localparam int DMEM_N = 256;  // data memory aliases on addr[7:0]
	localparam int TIMEOUT = 400; // cycles allowed per program

	logic clk;
	logic rst_n;
	word_t instr_data, dmem_rdata;
	word_t instr_addr, dmem_addr, dmem_wdata, wb_data;
	logic dmem_we, wb_en, stall, halted;
	reg_idx_t wb_reg;

	word_t imem [IMEM_N];
	word_t dmem [DMEM_N];
	word_t mdmem [DMEM_N];         // model copy of data memory
	word_t mregs [`CORE_NREGS];    // model register file
	reg_idx_t got_reg[$], exp_reg[$];
	word_t got_data[$], exp_data[$];
	int pulses[$];                 // lengths of finished stall pulses
	int run_len;
	int errors, checks;
	integer seed;

	core_top i_dut (
		.clk(clk), .rst_n(rst_n),
		.instr_data(instr_data), .dmem_rdata(dmem_rdata),
		.instr_addr(instr_addr), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.stall(stall), .halted(halted)
	);

	//******************************
	// clock and memory models
	//******************************
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	assign instr_data = imem[instr_addr[5:0]]; // same-cycle fetch
	assign dmem_rdata = dmem[dmem_addr[7:0]];

	always @(posedge clk) begin
		if (dmem_we)
			dmem[dmem_addr[7:0]] <= dmem_wdata;
	end

	// write-back stream and stall pulse monitor
	always @(posedge clk) begin
		if (rst_n) begin
			if (wb_en) begin
				got_reg.push_back(wb_reg);
				got_data.push_back(wb_data);
			end
			if (stall) begin
				run_len++;
			end else if (run_len > 0) begin
				pulses.push_back(run_len);
				run_len = 0;
			end
		end
	end

	//******************************
	// helpers
	//******************************
	function automatic word_t enc(opcode_t op, logic [3:0] a, logic [3:0] b, logic [3:0] c);
		return {op, a, b, c};
	endfunction

	function automatic word_t enc_imm(opcode_t op, logic [3:0] rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	task automatic check_word(string name, word_t exp, word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_idx(string name, reg_idx_t exp, reg_idx_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic clear_imem();
		for (int i = 0; i < IMEM_N; i++)
			imem[i] = enc(OP_HLT, 4'h0, 4'h0, 4'h0); // run-off lands on HLT
	endtask

	// instruction-level reference model
	task automatic run_model();
		word_t ins, addr;
		logic [3:0] op, rd, rs, rt;
		int pc;
		for (int i = 0; i < `CORE_NREGS; i++)
			mregs[i] = '0;
		exp_reg.delete();
		exp_data.delete();
		pc = 0;
		while (pc < IMEM_N) begin
			ins = imem[pc];
			{op, rd, rs, rt} = ins;
			addr = mregs[rs] + {{12{rt[3]}}, rt};
			if (op == 4'hf)
				break;
			case (op)
				4'h0: mregs[rd] = mregs[rs] + mregs[rt];
				4'h1: mregs[rd] = mregs[rs] - mregs[rt];
				4'h2: mregs[rd] = mregs[rs] ^ mregs[rt];
				4'h8: mregs[rd] = mdmem[addr[7:0]];
				4'h9: mdmem[addr[7:0]] = mregs[rd];
				4'ha: mregs[rd] = {ins[7:0], mregs[rd][7:0]};
				4'hb: mregs[rd] = {mregs[rd][15:8], ins[7:0]};
				default: ; // nop
			endcase
			if (op inside {4'h0, 4'h1, 4'h2, 4'h8, 4'ha, 4'hb}) begin
				exp_reg.push_back(rd);
				exp_data.push_back(mregs[rd]);
			end
			pc++;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		got_reg.delete();
		got_data.delete();
		pulses.delete();
		run_len = 0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
	endtask

	// bounded wait for the sticky halt level
	task automatic wait_for_halt(string name);
		int cyc;
		cyc = 0;
		while (!halted && cyc < TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (!halted) begin
			errors++;
			$display("%s: timed out waiting for halted", name);
		end
	endtask

	// preload memories, model the program, then run the DUT to halt
	task automatic run_program(string name);
		for (int a = 0; a < DMEM_N; a++) begin
			dmem[a] = {a[7:0], ~a[7:0]} ^ 16'h3c5a;
			mdmem[a] = dmem[a];
		end
		run_model();
		apply_reset();
		wait_for_halt(name);
	endtask

	task automatic compare_stream(string name);
		int n;
		if (got_reg.size() != exp_reg.size()) begin
			errors++;
			$display("%s: expected %0d write-backs, saw %0d", name, exp_reg.size(),
				got_reg.size());
		end
		n = (got_reg.size() < exp_reg.size()) ? got_reg.size() : exp_reg.size();
		for (int i = 0; i < n; i++) begin
			check_idx($sformatf("%s wb_reg[%0d]", name, i), exp_reg[i], got_reg[i]);
			check_word($sformatf("%s wb_data[%0d]", name, i), exp_data[i], got_data[i]);
		end
	endtask

	task automatic compare_dmem(string name);
		for (int a = 0; a < DMEM_N; a++)
			check_word($sformatf("%s dmem[%0d]", name, a), mdmem[a], dmem[a]);
	endtask

	task automatic report(string name, int base);
		$display("%s finished, %0d errors", name, errors - base);
	endtask

	//******************************
	// directed tests
	//******************************
	task automatic test_reset();
		int base;
		base = errors;
		clear_imem(); // first fetch is a HLT, so stall and halted go high
		apply_reset();
		wait_for_halt("reset");
		rst_n = 1'b0;
		@(negedge clk);
		check_bit("reset stall", 1'b0, stall);
		check_bit("reset halted", 1'b0, halted);
		check_bit("reset wb_en", 1'b0, wb_en);
		check_bit("reset dmem_we", 1'b0, dmem_we);
		check_word("reset instr_addr", '0, instr_addr);
		report("reset", base);
	endtask

	task automatic test_arith();
		int base;
		base = errors;
		clear_imem();
		imem[0] = enc_imm(OP_LLB, 4'd1, 8'h34);
		imem[1] = enc_imm(OP_LHB, 4'd1, 8'h12); // needs forward of r1
		imem[2] = enc_imm(OP_LLB, 4'd2, 8'h05);
		imem[3] = enc(OP_ADD, 4'd3, 4'd1, 4'd2); // r1 via write-through
		imem[4] = enc(OP_SUB, 4'd4, 4'd3, 4'd1);
		imem[5] = enc(OP_XOR, 4'd5, 4'd4, 4'd3);
		imem[6] = enc(OP_ADD, 4'd0, 4'd1, 4'd5); // r0 is a plain register
		run_program("arith");
		compare_stream("arith");
		report("arith", base);
	endtask

	task automatic test_load_use();
		int base;
		base = errors;
		clear_imem();
		imem[0] = enc_imm(OP_LLB, 4'd1, 8'h10);
		imem[1] = enc(OP_LW, 4'd2, 4'd1, 4'h2);
		imem[2] = enc(OP_ADD, 4'd3, 4'd2, 4'd2); // load-use pair
		run_program("load_use");
		compare_stream("load_use");
		check_word("load_use stall pulses", word_t'(1), word_t'(pulses.size()));
		if (pulses.size() > 0)
			check_word("load_use stall length", word_t'(1), word_t'(pulses[0]));
		clear_imem();
		imem[0] = enc_imm(OP_LLB, 4'd1, 8'h10);
		imem[1] = enc(OP_LW, 4'd2, 4'd1, 4'hf);  // negative offset
		imem[2] = enc(OP_ADD, 4'd3, 4'd1, 4'd1); // independent
		run_program("no_load_use");
		compare_stream("no_load_use");
		check_word("no_load_use stall pulses", '0, word_t'(pulses.size()));
		report("load_use", base);
	endtask

	task automatic test_store();
		int base;
		base = errors;
		clear_imem();
		imem[0] = enc_imm(OP_LLB, 4'd1, 8'h20);
		imem[1] = enc_imm(OP_LLB, 4'd2, 8'h77);
		imem[2] = enc(OP_SW, 4'd2, 4'd1, 4'h3); // rd forwarded from MEM
		imem[3] = enc(OP_LW, 4'd3, 4'd1, 4'h3);
		imem[4] = enc(OP_XOR, 4'd4, 4'd3, 4'd1);
		run_program("store");
		compare_stream("store");
		compare_dmem("store");
		report("store", base);
	endtask

	task automatic test_halt();
		int base;
		word_t pc_at_halt;
		base = errors;
		clear_imem();
		imem[0] = enc_imm(OP_LLB, 4'd1, 8'h0f);
		imem[1] = enc(OP_ADD, 4'd2, 4'd1, 4'd1);
		imem[2] = enc(OP_HLT, 4'h0, 4'h0, 4'h0);
		imem[3] = enc_imm(OP_LLB, 4'd7, 8'hff); // must never retire
		imem[4] = enc(OP_ADD, 4'd8, 4'd2, 4'd2);
		run_program("halt");
		pc_at_halt = instr_addr;
		repeat (6) @(negedge clk); // watch the frozen core a while
		check_bit("halt halted held", 1'b1, halted);
		check_word("halt instr_addr", pc_at_halt, instr_addr);
		compare_stream("halt");
		report("halt", base);
	endtask

	task automatic test_random();
		int base;
		int sel;
		opcode_t ops [7];
		base = errors;
		ops = '{OP_ADD, OP_SUB, OP_XOR, OP_LW, OP_SW, OP_LHB, OP_LLB};
		clear_imem();
		for (int i = 0; i < 40; i++) begin
			sel = $unsigned($random(seed)) % 7;
			imem[i] = {ops[sel], 12'($random(seed))};
		end
		run_program("random");
		compare_stream("random");
		compare_dmem("random");
		report("random", base);
	endtask

	//******************************
	// main sequence
	//******************************
	initial begin
		rst_n = 1'b0;
		errors = 0;
		checks = 0;
		run_len = 0;
		seed = 32'hc9cd;
		clear_imem();
		test_reset();
		test_arith();
		test_load_use();
		test_store();
		test_halt();
		test_random();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== tests/core_tb_asserts.sv ====
`timescale 1ns/100ps

module core_tb_asserts (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic halted,
	input logic is_hlt,
	input logic id_ex_valid,
	input logic id_ex_mem_to_reg
);

	logic lu_stall; // stall caused by a load alone

	assign lu_stall = stall && !is_hlt && !halted;

	//******************************
	// stall and halt rules
	//******************************
	a_lu_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		lu_stall |=> !lu_stall)
		else $error("load-use stall held for two cycles");

	a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
		else $error("halted fell without reset");

	// every stall needs a load in execute or a halt
	a_stall_cause: assert property (@(posedge clk) disable iff (!rst_n)
		stall |-> ((id_ex_valid && id_ex_mem_to_reg) || is_hlt || halted))
		else $error("stall without a load in execute or a halt");

endmodule

bind hazard_detection core_tb_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.stall(stall),
	.halted(halted),
	.is_hlt(is_hlt),
	.id_ex_valid(id_ex_valid),
	.id_ex_mem_to_reg(id_ex_mem_to_reg)
);
